/* gb_ppu_pkg.sv */
package gb_ppu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Frame timing, one clock per dot
  //////////////////////////////////////////////////////////////////////

  localparam logic [8:0] dots_per_line   = 9'd456;
  localparam logic [7:0] lines_per_frame = 8'd154;
  localparam logic [7:0] active_lines    = 8'd144;
  localparam logic [8:0] oam_dots        = 9'd80;
  localparam logic [8:0] transfer_dots   = 9'd172;
  localparam logic [7:0] screen_width    = 8'd160;

  // 20 visible tiles plus one for a fine scroll
  localparam logic [4:0] tiles_per_line  = 5'd21;

  //////////////////////////////////////////////////////////////////////
  // Bus decode and VRAM layout
  //////////////////////////////////////////////////////////////////////

  localparam logic [15:0] reg_base  = 16'hFF40;
  localparam logic [15:0] vram_base = 16'h8000;
  localparam logic [15:0] vram_top  = 16'hA000;

  // Offsets inside VRAM
  localparam logic [15:0] map_low          = 16'h1800;
  localparam logic [15:0] map_high         = 16'h1C00;
  localparam logic [15:0] tile_signed_base = 16'h1000;

  // Palette after reset, shades 3 3 3 0
  localparam logic [7:0] bgp_reset = 8'hFC;

  // STAT mode field encoding
  typedef enum logic [1:0] {
    hblank     = 2'd0,
    vblank     = 2'd1,
    oam_search = 2'd2,
    transfer   = 2'd3
  } ppu_mode_e;

  // Low byte of the register address
  typedef enum logic [7:0] {
    reg_lcdc = 8'h40,
    reg_stat = 8'h41,
    reg_scy  = 8'h42,
    reg_scx  = 8'h43,
    reg_ly   = 8'h44,
    reg_lyc  = 8'h45,
    reg_bgp  = 8'h47
  } reg_addr_e;

  typedef enum logic [2:0] {
    idle,
    map_addr,
    map_data,
    row_data,
    hand_off
  } fetch_state_e;

  // CPU visible control registers
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic [3:0] stat_enable;  // STAT bits 6:3, LYC OAM VBL HBL
  } ppu_ctrl_t;

  // Beam position and current mode
  typedef struct packed {
    logic [7:0] ly;
    logic [8:0] dot;
    ppu_mode_e  mode;
  } raster_t;

  // One tile row, two bit planes
  typedef struct packed {
    logic [7:0] low;
    logic [7:0] high;
    logic       first;
  } tile_row_t;

endpackage

/* ppu_regs.sv */
`timescale 1ns/1ns

module ppu_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [15:0]           addr,
  input  logic [7:0]            wdata,
  input  logic                  rd,
  input  logic                  wr,
  input  logic                  cs,
  output logic [7:0]            rdata,
  input  gb_ppu_pkg::raster_t   raster,
  output gb_ppu_pkg::ppu_ctrl_t ctrl,
  output logic [12:0]           vram_cpu_addr,
  output logic                  vram_cpu_we,
  input  logic [7:0]            vram_cpu_rdata
);

  logic        reg_hit;
  logic        vram_hit;
  logic        lcd_busy;
  logic [15:0] vram_off;
  logic [7:0]  stat;
  logic [7:0]  reg_rdata;
  logic [7:0]  rdata_q;
  logic        rd_vram_q;
  logic        rd_block_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  // Register page FF40..FF4F
  assign reg_hit  = cs && (addr[15:8] == gb_ppu_pkg::reg_base[15:8]) &&
                    (addr[7:4] == gb_ppu_pkg::reg_base[7:4]);
  assign vram_hit = cs && (addr >= gb_ppu_pkg::vram_base) && (addr < gb_ppu_pkg::vram_top);

  // CPU locked out of VRAM while pixels are transferred
  assign lcd_busy = (raster.mode == gb_ppu_pkg::transfer);

  assign vram_off      = addr - gb_ppu_pkg::vram_base;
  assign vram_cpu_addr = vram_off[12:0];
  assign vram_cpu_we   = vram_hit && wr && !lcd_busy;

  // Top bit unused and reads high
  assign stat = {1'b1, ctrl.stat_enable, (raster.ly == ctrl.lyc), raster.mode};

  always_comb begin
    case (gb_ppu_pkg::reg_addr_e'(addr[7:0]))
      gb_ppu_pkg::reg_lcdc: reg_rdata = ctrl.lcdc;
      gb_ppu_pkg::reg_stat: reg_rdata = stat;
      gb_ppu_pkg::reg_scy:  reg_rdata = ctrl.scy;
      gb_ppu_pkg::reg_scx:  reg_rdata = ctrl.scx;
      gb_ppu_pkg::reg_ly:   reg_rdata = raster.ly;
      gb_ppu_pkg::reg_lyc:  reg_rdata = ctrl.lyc;
      gb_ppu_pkg::reg_bgp:  reg_rdata = ctrl.bgp;
      default:              reg_rdata = 8'hFF;
    endcase
    // Anything outside the page floats high
    if (!reg_hit) begin
      reg_rdata = 8'hFF;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      ctrl     <= '0;
      ctrl.bgp <= gb_ppu_pkg::bgp_reset;
    end else if (reg_hit && wr) begin
      case (gb_ppu_pkg::reg_addr_e'(addr[7:0]))
        gb_ppu_pkg::reg_lcdc: ctrl.lcdc <= wdata;
        gb_ppu_pkg::reg_stat: ctrl.stat_enable <= wdata[6:3];
        gb_ppu_pkg::reg_scy:  ctrl.scy <= wdata;
        gb_ppu_pkg::reg_scx:  ctrl.scx <= wdata;
        gb_ppu_pkg::reg_lyc:  ctrl.lyc <= wdata;
        gb_ppu_pkg::reg_bgp:  ctrl.bgp <= wdata;
        // LY is read only here
        default: ;
      endcase
    end
  end

  // Read data one cycle after the strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_vram_q  <= 1'b0;
      rd_block_q <= 1'b0;
      rdata_q    <= 8'hFF;
    end else begin
      rd_vram_q  <= vram_hit && rd;
      rd_block_q <= lcd_busy;
      if (cs && rd) begin
        rdata_q <= reg_rdata;
      end
    end
  end

  // VRAM data arrives from the memory in the same cycle
  assign rdata = rd_vram_q ? (rd_block_q ? 8'hFF : vram_cpu_rdata) : rdata_q;

  // Counters in the transfer window must lock the write one cycle on
  a_no_vram_write_in_transfer: assert property (@(posedge clock) disable iff (reset)
    (ctrl.lcdc[7] && (raster.ly < gb_ppu_pkg::active_lines) &&
     (raster.dot >= gb_ppu_pkg::oam_dots) &&
     (raster.dot < gb_ppu_pkg::oam_dots + gb_ppu_pkg::transfer_dots))
    |=> !vram_cpu_we);

endmodule

/* lcd_timing.sv */
`timescale 1ns/1ns

module lcd_timing (
  input  logic                  clock,
  input  logic                  reset,
  input  gb_ppu_pkg::ppu_ctrl_t ctrl,
  output gb_ppu_pkg::raster_t   raster,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  vblank_req,
  input  logic                  vblank_ack,
  output logic                  lcd_req,
  input  logic                  lcd_ack
);

  logic [8:0]            dot;
  logic [7:0]            ly;
  gb_ppu_pkg::ppu_mode_e mode;
  gb_ppu_pkg::ppu_mode_e mode_next;
  logic                  lcd_on;
  logic                  mode_entry;
  logic                  stat_hit;
  logic                  lyc_hit;

  assign lcd_on = ctrl.lcdc[7];

  //////////////////////////////////////////////////////////////////////
  // Dot and line counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || !lcd_on) begin
      dot <= 9'd0;
      ly  <= 8'd0;
    end else if (dot == gb_ppu_pkg::dots_per_line - 9'd1) begin
      dot <= 9'd0;
      ly  <= (ly == gb_ppu_pkg::lines_per_frame - 8'd1) ? 8'd0 : ly + 8'd1;
    end else begin
      dot <= dot + 9'd1;
    end
  end

  // Mode from the counters, registered below so it lags by one dot
  always_comb begin
    if (!lcd_on) begin
      mode_next = gb_ppu_pkg::hblank;
    end else if (ly >= gb_ppu_pkg::active_lines) begin
      mode_next = gb_ppu_pkg::vblank;
    end else if (dot < gb_ppu_pkg::oam_dots) begin
      mode_next = gb_ppu_pkg::oam_search;
    end else if (dot < gb_ppu_pkg::oam_dots + gb_ppu_pkg::transfer_dots) begin
      mode_next = gb_ppu_pkg::transfer;
    end else begin
      mode_next = gb_ppu_pkg::hblank;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Interrupt requests
  //////////////////////////////////////////////////////////////////////

  assign mode_entry = lcd_on && (mode_next != mode);

  // Transfer has no STAT source
  assign stat_hit = mode_entry &&
                    (((mode_next == gb_ppu_pkg::hblank)     && ctrl.stat_enable[0]) ||
                     ((mode_next == gb_ppu_pkg::vblank)     && ctrl.stat_enable[1]) ||
                     ((mode_next == gb_ppu_pkg::oam_search) && ctrl.stat_enable[2]));

  // Coincidence fires once at the start of the matching line
  assign lyc_hit = lcd_on && (dot == 9'd0) && (ly == ctrl.lyc) && ctrl.stat_enable[3];

  always_ff @(posedge clock) begin
    if (reset) begin
      mode       <= gb_ppu_pkg::hblank;
      vblank_req <= 1'b0;
      lcd_req    <= 1'b0;
    end else begin
      mode <= mode_next;
      // A new request wins over an ack in the same cycle
      if (vblank_ack) begin
        vblank_req <= 1'b0;
      end
      if (mode_entry && (mode_next == gb_ppu_pkg::vblank)) begin
        vblank_req <= 1'b1;
      end
      if (lcd_ack) begin
        lcd_req <= 1'b0;
      end
      if (stat_hit || lyc_hit) begin
        lcd_req <= 1'b1;
      end
    end
  end

  // Sync from the counters
  assign hsync = dot > (gb_ppu_pkg::oam_dots + gb_ppu_pkg::transfer_dots +
                        gb_ppu_pkg::screen_width);
  assign vsync = ly > gb_ppu_pkg::active_lines;

  assign raster = '{ly: ly, dot: dot, mode: mode};

  a_raster_range: assert property (@(posedge clock) disable iff (reset)
    (dot < gb_ppu_pkg::dots_per_line) && (ly < gb_ppu_pkg::lines_per_frame));

endmodule

/* ppu_vram.sv */
`timescale 1ns/1ns

module ppu_vram (
  input  logic        clock,
  input  logic [12:0] cpu_addr,
  input  logic        cpu_we,
  input  logic [7:0]  cpu_wdata,
  output logic [7:0]  cpu_rdata,
  input  logic [12:0] rd_addr_a,
  input  logic [12:0] rd_addr_b,
  output logic [7:0]  rd_data_a,
  output logic [7:0]  rd_data_b
);

  // 8 KB window from the bus map
  logic [7:0] mem [0:gb_ppu_pkg::vram_top - gb_ppu_pkg::vram_base - 1];

  // CPU port, write and read share one address
  always_ff @(posedge clock) begin
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    cpu_rdata <= mem[cpu_addr];
  end

  // Render ports, map entry on A and the two tile planes on A and B
  always_ff @(posedge clock) begin
    rd_data_a <= mem[rd_addr_a];
    rd_data_b <= mem[rd_addr_b];
  end

endmodule

/* bg_fetch.sv */
`timescale 1ns/1ns

module bg_fetch (
  input  logic                  clock,
  input  logic                  reset,
  input  gb_ppu_pkg::ppu_ctrl_t ctrl,
  input  gb_ppu_pkg::raster_t   raster,
  output logic [12:0]           rd_addr_a,
  output logic [12:0]           rd_addr_b,
  input  logic [7:0]            rd_data_a,
  input  logic [7:0]            rd_data_b,
  output gb_ppu_pkg::tile_row_t row,
  output logic                  row_valid,
  input  logic                  busy
);

  gb_ppu_pkg::fetch_state_e state;
  gb_ppu_pkg::ppu_mode_e    mode_q;
  logic [4:0]               tile;
  logic [7:0]               line_y;
  logic [4:0]               map_col;
  logic [12:0]              map_base;
  logic [12:0]              map_ptr;
  logic [12:0]              row_addr;
  logic                     start;
  logic                     last_tile;
  logic                     hand_ok;

  //////////////////////////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////////////////////////

  // Background line after vertical scroll, wraps at 256
  assign line_y = ctrl.scy + raster.ly;

  // Coarse scroll column wraps inside the 32 wide map
  assign map_col  = ctrl.scx[7:3] + tile;
  assign map_base = ctrl.lcdc[3] ? gb_ppu_pkg::map_high[12:0] : gb_ppu_pkg::map_low[12:0];
  assign map_ptr  = map_base + {3'b000, line_y[7:3], map_col};

  // Tile index arrives on port A in map_data
  always_comb begin
    if (ctrl.lcdc[4]) begin
      row_addr = {1'b0, rd_data_a, line_y[2:0], 1'b0};
    end else begin
      // Signed index around the middle of tile data
      row_addr = gb_ppu_pkg::tile_signed_base[12:0] +
                 {rd_data_a[7], rd_data_a, line_y[2:0], 1'b0};
    end
  end

  assign rd_addr_a = (state == gb_ppu_pkg::map_addr) ? map_ptr : row_addr;
  // High plane sits one byte above the low plane
  assign rd_addr_b = row_addr + 13'd1;

  //////////////////////////////////////////////////////////////////////
  // Fetch FSM
  //////////////////////////////////////////////////////////////////////

  assign start     = (raster.mode == gb_ppu_pkg::transfer) && (mode_q != gb_ppu_pkg::transfer);
  assign last_tile = (tile == gb_ppu_pkg::tiles_per_line - 5'd1);

  // Row goes out once the shifter can take it
  assign hand_ok = ((state == gb_ppu_pkg::row_data) || (state == gb_ppu_pkg::hand_off)) &&
                   !busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= gb_ppu_pkg::idle;
      mode_q    <= gb_ppu_pkg::hblank;
      tile      <= 5'd0;
      row_valid <= 1'b0;
    end else begin
      mode_q    <= raster.mode;
      row_valid <= 1'b0;
      case (state)
        gb_ppu_pkg::idle: begin
          if (start) begin
            tile  <= 5'd0;
            state <= gb_ppu_pkg::map_addr;
          end
        end
        gb_ppu_pkg::map_addr: state <= gb_ppu_pkg::map_data;
        gb_ppu_pkg::map_data: state <= gb_ppu_pkg::row_data;
        // Stall here until busy drops
        gb_ppu_pkg::row_data: state <= gb_ppu_pkg::hand_off;
        gb_ppu_pkg::hand_off: ;
        default: state <= gb_ppu_pkg::idle;
      endcase
      if (hand_ok) begin
        row_valid <= 1'b1;
        tile      <= tile + 5'd1;
        state     <= last_tile ? gb_ppu_pkg::idle : gb_ppu_pkg::map_addr;
      end
    end
  end

  // Capture both planes, background off sends blank rows
  always_ff @(posedge clock) begin
    if (state == gb_ppu_pkg::row_data) begin
      row.low   <= ctrl.lcdc[0] ? rd_data_a : 8'h00;
      row.high  <= ctrl.lcdc[0] ? rd_data_b : 8'h00;
      row.first <= (tile == 5'd0);
    end
  end

  // Back pressure seen across the fetcher and shifter pair
  a_valid_not_busy: assert property (@(posedge clock) disable iff (reset)
    row_valid |-> !busy);

endmodule

/* pixel_shifter.sv */
`timescale 1ns/1ns

module pixel_shifter (
  input  logic                  clock,
  input  logic                  reset,
  input  gb_ppu_pkg::ppu_ctrl_t ctrl,
  input  gb_ppu_pkg::raster_t   raster,
  input  gb_ppu_pkg::tile_row_t row,
  input  logic                  row_valid,
  output logic                  busy,
  output logic [1:0]            pixel_data,
  output logic                  pixel_latch,
  output logic [7:0]            pixel_x
);

  logic [7:0] shift_lo;
  logic [7:0] shift_hi;
  logic [3:0] count;     // pixels left in the row
  logic [7:0] x_count;
  logic [2:0] fine;
  logic [1:0] color;
  logic       in_line;

  // Fine scroll only trims the first tile of a line
  assign fine    = row.first ? ctrl.scx[2:0] : 3'd0;
  assign color   = {shift_hi[7], shift_lo[7]};
  assign in_line = (x_count < gb_ppu_pkg::screen_width);

  // Low two pixels early, so the next row lands right after the last pixel
  assign busy = (count > 4'd2);

  always_ff @(posedge clock) begin
    if (reset) begin
      count       <= 4'd0;
      x_count     <= gb_ppu_pkg::screen_width;
      pixel_latch <= 1'b0;
    end else begin
      pixel_latch <= (count != 4'd0) && in_line;
      if (count != 4'd0) begin
        count <= count - 4'd1;
        if (in_line) begin
          x_count <= x_count + 8'd1;
        end
      end
      if (row_valid) begin
        count <= 4'd8 - {1'b0, fine};
        if (row.first) begin
          x_count <= 8'd0;
        end
      end
      // Flush anything left at the start of a line
      if (raster.mode == gb_ppu_pkg::oam_search) begin
        count <= 4'd0;
      end
    end
  end

  // MSB first, dropped pixels shifted out on load
  always_ff @(posedge clock) begin
    if (row_valid) begin
      shift_lo <= row.low << fine;
      shift_hi <= row.high << fine;
    end else begin
      shift_lo <= shift_lo << 1;
      shift_hi <= shift_hi << 1;
    end
    pixel_data <= ctrl.bgp[{color, 1'b0} +: 2];
    pixel_x    <= x_count;
  end

endmodule

/* gb_ppu.sv */
`timescale 1ns/1ns

module gb_ppu (
  input  logic        clock,
  input  logic        reset,
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        rd,
  input  logic        wr,
  input  logic        cs,
  output logic [7:0]  rdata,
  output logic        vblank_req,
  input  logic        vblank_ack,
  output logic        lcd_req,
  input  logic        lcd_ack,
  output logic        hsync,
  output logic        vsync,
  output logic [7:0]  ly,
  output logic [1:0]  pixel_data,
  output logic        pixel_latch,
  output logic [7:0]  pixel_x
);

  gb_ppu_pkg::ppu_ctrl_t ctrl;
  gb_ppu_pkg::raster_t   raster;
  gb_ppu_pkg::tile_row_t row;
  logic                  row_valid;
  logic                  busy;
  logic [12:0]           vram_cpu_addr;
  logic                  vram_cpu_we;
  logic [7:0]            vram_cpu_rdata;
  logic [12:0]           vram_rd_addr_a;
  logic [12:0]           vram_rd_addr_b;
  logic [7:0]            vram_rd_data_a;
  logic [7:0]            vram_rd_data_b;

  assign ly = raster.ly;

  //////////////////////////////////////////////////////////////////////
  // CPU side
  //////////////////////////////////////////////////////////////////////

  ppu_regs u_regs (
    .clock          (clock),
    .reset          (reset),
    .addr           (addr),
    .wdata          (wdata),
    .rd             (rd),
    .wr             (wr),
    .cs             (cs),
    .rdata          (rdata),
    .raster         (raster),
    .ctrl           (ctrl),
    .vram_cpu_addr  (vram_cpu_addr),
    .vram_cpu_we    (vram_cpu_we),
    .vram_cpu_rdata (vram_cpu_rdata)
  );

  lcd_timing u_timing (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .raster     (raster),
    .hsync      (hsync),
    .vsync      (vsync),
    .vblank_req (vblank_req),
    .vblank_ack (vblank_ack),
    .lcd_req    (lcd_req),
    .lcd_ack    (lcd_ack)
  );

  // Bus write data goes straight to the memory
  ppu_vram u_vram (
    .clock     (clock),
    .cpu_addr  (vram_cpu_addr),
    .cpu_we    (vram_cpu_we),
    .cpu_wdata (wdata),
    .cpu_rdata (vram_cpu_rdata),
    .rd_addr_a (vram_rd_addr_a),
    .rd_addr_b (vram_rd_addr_b),
    .rd_data_a (vram_rd_data_a),
    .rd_data_b (vram_rd_data_b)
  );

  //////////////////////////////////////////////////////////////////////
  // Render path
  //////////////////////////////////////////////////////////////////////

  bg_fetch u_fetch (
    .clock     (clock),
    .reset     (reset),
    .ctrl      (ctrl),
    .raster    (raster),
    .rd_addr_a (vram_rd_addr_a),
    .rd_addr_b (vram_rd_addr_b),
    .rd_data_a (vram_rd_data_a),
    .rd_data_b (vram_rd_data_b),
    .row       (row),
    .row_valid (row_valid),
    .busy      (busy)
  );

  pixel_shifter u_shifter (
    .clock       (clock),
    .reset       (reset),
    .ctrl        (ctrl),
    .raster      (raster),
    .row         (row),
    .row_valid   (row_valid),
    .busy        (busy),
    .pixel_data  (pixel_data),
    .pixel_latch (pixel_latch),
    .pixel_x     (pixel_x)
  );

endmodule

/* tb_gb_ppu.sv */
`timescale 1ns/1ns

module tb_gb_ppu;

  // One pixel test: registers to load and two lines to compare
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] bgp;
    logic [7:0] lyc;
    logic [7:0] line_a;
    logic [7:0] line_b;
  } pixel_case_t;

  localparam int num_cases    = 6;
  localparam int frame_cycles = 456 * 154;

  logic        clock;
  logic        reset;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        rd;
  logic        wr;
  logic        cs;
  logic [7:0]  rdata;
  logic        vblank_req;
  logic        vblank_ack;
  logic        lcd_req;
  logic        lcd_ack;
  logic        hsync;
  logic        vsync;
  logic [7:0]  ly;
  logic [1:0]  pixel_data;
  logic        pixel_latch;
  logic [7:0]  pixel_x;

  int          checks;
  int          errors;
  logic [7:0]  vram_model [0:8191];

  // Map selects, signed tiles, fine scroll, SCY wrap, palettes, background off
  pixel_case_t cases [0:num_cases-1] = '{
    '{8'h91, 8'h00, 8'h00, 8'hE4, 8'h00, 8'd1,  8'd77},
    '{8'h99, 8'h13, 8'h05, 8'h1B, 8'h02, 8'd2,  8'd143},
    '{8'h81, 8'hF7, 8'hF0, 8'hD2, 8'h0A, 8'd10, 8'd20},
    '{8'h89, 8'h2D, 8'h88, 8'h93, 8'h30, 8'd33, 8'd100},
    '{8'h90, 8'h41, 8'h17, 8'h27, 8'h05, 8'd5,  8'd60},
    '{8'h97, 8'h07, 8'h3C, 8'hE4, 8'h44, 8'd8,  8'd121}
  };

  gb_ppu uut (
    .clock       (clock),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .rd          (rd),
    .wr          (wr),
    .cs          (cs),
    .rdata       (rdata),
    .vblank_req  (vblank_req),
    .vblank_ack  (vblank_ack),
    .lcd_req     (lcd_req),
    .lcd_ack     (lcd_ack),
    .hsync       (hsync),
    .vsync       (vsync),
    .ly          (ly),
    .pixel_data  (pixel_data),
    .pixel_latch (pixel_latch),
    .pixel_x     (pixel_x)
  );

  always #5 clock = ~clock;

  // Ends a stuck run, two frames per test plus one for the VRAM fill
  initial begin
    #((num_cases + 4) * 2 * frame_cycles * 10 + frame_cycles * 10);
    $display("Watchdog timeout, the run did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////

  // Galois form, right shift
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hA3000000) : (state >> 1);
  endfunction

  // Background pixel from the tile map rules
  function automatic logic [1:0] expected_pixel(input pixel_case_t tc, input int line,
                                                input int x);
    int         bx;
    int         by;
    int         map_a;
    int         tile_a;
    int         sidx;
    int         bitn;
    logic [7:0] idx;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] c;
    bx    = (int'(tc.scx) + x) % 256;
    by    = (int'(tc.scy) + line) % 256;
    map_a = (tc.lcdc[3] ? 'h1C00 : 'h1800) + 32 * (by / 8) + (bx / 8) % 32;
    idx   = vram_model[map_a];
    sidx  = idx[7] ? int'(idx) - 256 : int'(idx);
    // Bit 4 clear uses a signed index around 0x1000
    if (tc.lcdc[4]) begin
      tile_a = int'(idx) * 16 + 2 * (by % 8);
    end else begin
      tile_a = 4096 + sidx * 16 + 2 * (by % 8);
    end
    lo   = vram_model[tile_a];
    hi   = vram_model[tile_a + 1];
    bitn = 7 - bx % 8;
    c    = tc.lcdc[0] ? {hi[bitn], lo[bitn]} : 2'b00;
    return tc.bgp[int'(c) * 2 +: 2];
  endfunction

  task automatic expect_value(input logic [31:0] got, input logic [31:0] want,
                              input string what);
    checks++;
    assert (got === want) else begin
      $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  // Write seen on the next edge
  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    addr  = a;
    wdata = d;
    wr    = 1'b1;
    cs    = 1'b1;
    step(1);
    wr = 1'b0;
    cs = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
    addr = a;
    rd   = 1'b1;
    cs   = 1'b1;
    step(1);
    rd = 1'b0;
    cs = 1'b0;
    d  = rdata;
  endtask

  // Returns just after the edge where ly turns to the line, with dot at 0
  task automatic wait_line(input logic [7:0] line);
    while (ly == line) step(1);
    while (ly != line) step(1);
  endtask

  task automatic ack_pulse(input logic vbl, input logic lcd);
    vblank_ack = vbl;
    lcd_ack    = lcd;
    step(1);
    vblank_ack = 1'b0;
    lcd_ack    = 1'b0;
  endtask

  task automatic check_reg(input logic [15:0] a, input logic [7:0] want, input string what);
    logic [7:0] d;
    bus_read(a, d);
    expect_value(32'(d), 32'(want), what);
  endtask

  task automatic stat_mode_at(input logic [7:0] line, input int dot, input logic [1:0] want);
    logic [7:0] d;
    wait_line(line);
    step(dot);
    bus_read(16'hFF41, d);
    expect_value(32'(d[1:0]), 32'(want), $sformatf("STAT mode line %0d dot %0d", line, dot));
  endtask

  // Collects one line of pixels against the model
  task automatic check_line(input pixel_case_t tc, input logic [7:0] line);
    int n;
    n = 0;
    wait_line(line);
    repeat (320) begin
      @(negedge clock);
      if (pixel_latch) begin
        if (n < 160) begin
          expect_value(32'(pixel_x), 32'(n), $sformatf("pixel_x line %0d", line));
          expect_value(32'(pixel_data), 32'(expected_pixel(tc, int'(line), n)),
                       $sformatf("pixel line %0d x %0d", line, n));
        end
        n++;
      end
    end
    @(posedge clock);
    #1;
    expect_value(32'(n), 32'd160, $sformatf("latch count line %0d", line));
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] state;
    logic [7:0]  byte_v;
    logic [7:0]  d;
    int          e0;
    clock      = 1'b0;
    reset      = 1'b1;
    addr       = 16'h0000;
    wdata      = 8'h00;
    rd         = 1'b0;
    wr         = 1'b0;
    cs         = 1'b0;
    vblank_ack = 1'b0;
    lcd_ack    = 1'b0;
    checks     = 0;
    errors     = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // Register readback with the LCD off
    e0 = errors;
    // Outputs quiet out of reset
    expect_value(32'(vblank_req), 32'd0, "vblank_req after reset");
    expect_value(32'(lcd_req), 32'd0, "lcd_req after reset");
    expect_value(32'(hsync), 32'd0, "hsync after reset");
    expect_value(32'(vsync), 32'd0, "vsync after reset");
    expect_value(32'(pixel_latch), 32'd0, "pixel_latch after reset");
    check_reg(16'hFF47, 8'hFC, "BGP after reset");
    bus_write(16'hFF40, 8'h5A);
    check_reg(16'hFF40, 8'h5A, "LCDC");
    bus_write(16'hFF42, 8'h3C);
    check_reg(16'hFF42, 8'h3C, "SCY");
    bus_write(16'hFF43, 8'hA5);
    check_reg(16'hFF43, 8'hA5, "SCX");
    bus_write(16'hFF45, 8'h91);
    check_reg(16'hFF45, 8'h91, "LYC");
    bus_write(16'hFF47, 8'h1B);
    check_reg(16'hFF47, 8'h1B, "BGP");
    // Enables stored, no coincidence, mode 0
    bus_write(16'hFF41, 8'hFF);
    check_reg(16'hFF41, 8'hF8, "STAT");
    bus_write(16'hFF44, 8'h55);
    check_reg(16'hFF44, 8'h00, "LY");
    check_reg(16'hFF4A, 8'hFF, "unmapped FF4A");
    check_reg(16'h1234, 8'hFF, "unmapped 1234");
    bus_write(16'hFF40, 8'h00);
    bus_write(16'hFF41, 8'h00);
    report_test("registers", e0);

    // VRAM fill from the LFSR, one step per bit
    state = 32'h61b397df;
    for (int i = 0; i < 8192; i++) begin
      for (int b = 0; b < 8; b++) begin
        byte_v[b] = state[0];
        state     = lfsr_step(state);
      end
      vram_model[i] = byte_v;
      bus_write(16'h8000 + 16'(i), byte_v);
    end

    // Mode rule and LY wrap
    e0 = errors;
    bus_write(16'hFF40, 8'h91);
    stat_mode_at(8'd5, 40, 2'd2);
    stat_mode_at(8'd6, 150, 2'd3);
    stat_mode_at(8'd7, 300, 2'd0);
    // Horizontal sync starts after dot 412
    wait_line(8'd8);
    step(412);
    expect_value(32'(hsync), 32'd0, "hsync at dot 412");
    step(1);
    expect_value(32'(hsync), 32'd1, "hsync at dot 413");
    // Vertical sync starts after line 144
    wait_line(8'd144);
    expect_value(32'(vsync), 32'd0, "vsync on line 144");
    wait_line(8'd145);
    expect_value(32'(vsync), 32'd1, "vsync on line 145");
    stat_mode_at(8'd150, 40, 2'd1);
    wait_line(8'd153);
    while (ly == 8'd153) step(1);
    expect_value(32'(ly), 32'd0, "LY after line 153");
    expect_value(32'(vsync), 32'd0, "vsync after wrap");
    bus_write(16'hFF40, 8'h11);
    step(10);
    check_reg(16'hFF44, 8'h00, "LY with LCD off");
    check_reg(16'hFF41, 8'h80, "STAT with LCD off");
    step(500);
    check_reg(16'hFF44, 8'h00, "LY held with LCD off");
    report_test("timing", e0);

    // Interrupt requests
    e0 = errors;
    bus_write(16'hFF40, 8'h91);
    wait_line(8'd143);
    ack_pulse(1'b1, 1'b1);
    step(400);
    expect_value(32'(vblank_req), 32'd0, "vblank_req before 144");
    wait_line(8'd144);
    step(2);
    expect_value(32'(vblank_req), 32'd1, "vblank_req at 144");
    ack_pulse(1'b1, 1'b0);
    expect_value(32'(vblank_req), 32'd0, "vblank_req after ack");
    wait_line(8'd0);
    wait_line(8'd143);
    expect_value(32'(vblank_req), 32'd0, "vblank_req once per frame");
    // HBlank source
    bus_write(16'hFF41, 8'h08);
    wait_line(8'd10);
    ack_pulse(1'b0, 1'b1);
    step(100);
    expect_value(32'(lcd_req), 32'd0, "lcd_req before hblank");
    step(200);
    expect_value(32'(lcd_req), 32'd1, "lcd_req on hblank");
    ack_pulse(1'b0, 1'b1);
    expect_value(32'(lcd_req), 32'd0, "lcd_req after ack");
    // OAM source, hblank entry must stay quiet
    bus_write(16'hFF41, 8'h20);
    wait_line(8'd11);
    step(2);
    ack_pulse(1'b0, 1'b1);
    step(300);
    expect_value(32'(lcd_req), 32'd0, "lcd_req in hblank");
    wait_line(8'd12);
    step(3);
    expect_value(32'(lcd_req), 32'd1, "lcd_req on OAM search");
    // VBlank source
    bus_write(16'hFF41, 8'h10);
    wait_line(8'd143);
    ack_pulse(1'b1, 1'b1);
    step(400);
    expect_value(32'(lcd_req), 32'd0, "lcd_req before vblank");
    wait_line(8'd144);
    step(2);
    expect_value(32'(lcd_req), 32'd1, "lcd_req on vblank");
    // LY equals LYC
    bus_write(16'hFF45, 8'd20);
    bus_write(16'hFF41, 8'h40);
    wait_line(8'd19);
    ack_pulse(1'b1, 1'b1);
    step(100);
    expect_value(32'(lcd_req), 32'd0, "lcd_req before LYC line");
    wait_line(8'd20);
    step(2);
    expect_value(32'(lcd_req), 32'd1, "lcd_req on LYC match");
    bus_read(16'hFF41, d);
    expect_value(32'(d[2]), 32'd1, "coincidence on LYC line");
    ack_pulse(1'b0, 1'b1);
    wait_line(8'd21);
    step(2);
    bus_read(16'hFF41, d);
    expect_value(32'(d[2]), 32'd0, "coincidence off LYC line");
    expect_value(32'(lcd_req), 32'd0, "lcd_req after LYC ack");
    report_test("interrupts", e0);

    // VRAM lockout in transfer
    e0 = errors;
    wait_line(8'd30);
    step(150);
    bus_write(16'h8123, ~vram_model[12'h123]);
    check_reg(16'h8123, 8'hFF, "VRAM read in transfer");
    step(148);
    check_reg(16'h8123, vram_model[12'h123], "VRAM after blocked write");
    bus_write(16'h8123, 8'h5C);
    vram_model[12'h123] = 8'h5C;
    check_reg(16'h8123, 8'h5C, "VRAM write in hblank");
    report_test("vram lockout", e0);

    // Background pixels from the table
    for (int t = 0; t < num_cases; t++) begin
      e0 = errors;
      bus_write(16'hFF40, 8'h00);
      bus_write(16'hFF43, cases[t].scx);
      bus_write(16'hFF42, cases[t].scy);
      bus_write(16'hFF47, cases[t].bgp);
      bus_write(16'hFF45, cases[t].lyc);
      bus_write(16'hFF40, cases[t].lcdc);
      check_line(cases[t], cases[t].line_a);
      check_line(cases[t], cases[t].line_b);
      report_test($sformatf("pixels %0d", t), e0);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* gb_ppu.f */
gb_ppu_pkg.sv
ppu_regs.sv
lcd_timing.sv
ppu_vram.sv
bg_fetch.sv
pixel_shifter.sv
gb_ppu.sv
tb_gb_ppu.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, pass only when the log holds the pass line
rm -f sim.log
verilator --binary --timing --assert --top-module tb_gb_ppu -f gb_ppu.f \
  -o sim_gb_ppu > build.log 2>&1 \
  && ./obj_dir/sim_gb_ppu > sim.log 2>&1 \
  || echo "build or simulation error, see build.log and sim.log"
grep -q "STATUS: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
